// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_mem_stage
FILELIST = files.f

BUILD = obj_dir
BIN   = $(BUILD)/V$(TOP)
LOG   = sim.log
SRCS  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: data_sram.sv
`timescale 1ns/1ps
`default_nettype none

module data_sram (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               ce_i,
    input  logic               we_i,
    input  mem_pkg::addr_t     addr_i,
    input  mem_pkg::byte_sel_t sel_i,
    input  mem_pkg::word_t     wdata_i,
    output mem_pkg::word_t     rdata_o,
    output logic               data_ok_o
);
    import mem_pkg::*;

    word_t                  mem_array [0:MEM_DEPTH_WORDS-1];
    logic [MEM_INDEX_W-1:0] index;

    // Word index without the byte offset
    assign index = addr_i[MEM_INDEX_W+1:2];

    always_ff @(posedge clk) begin
        if (ce_i) begin
            if (we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (sel_i[i]) begin
                        mem_array[index][8*i +: 8] <= wdata_i[8*i +: 8];
                    end
                end
            end
            // Old contents on a write cycle
            rdata_o <= mem_array[index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            data_ok_o <= 1'b0;
        end else begin
            data_ok_o <= ce_i;
        end
    end

endmodule

`default_nettype wire

// File: files.f
mem_pkg.sv
store_align.sv
load_extract.sv
data_sram.sv
mem_ctrl.sv
mem_stage_top.sv
mem_checker.sv
tb_mem_stage.sv

// File: load_extract.sv
`timescale 1ns/1ps
`default_nettype none

module load_extract (
    input  mem_pkg::mem_op_e op_i,
    input  logic [1:0]       addr_low_i,
    input  mem_pkg::word_t   rdata_i,
    output mem_pkg::word_t   value_o
);
    import mem_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;

    // Addressed lanes of the returned word
    always_comb begin
        case (addr_low_i)
            2'b00:   byte_lane = rdata_i[7:0];
            2'b01:   byte_lane = rdata_i[15:8];
            2'b10:   byte_lane = rdata_i[23:16];
            default: byte_lane = rdata_i[31:24];
        endcase
        half_lane = addr_low_i[1] ? rdata_i[31:16] : rdata_i[15:0];
    end

    always_comb begin
        case (op_i)
            OP_LD_B:  value_o = {{24{byte_lane[7]}}, byte_lane};
            OP_LD_BU: value_o = {24'd0, byte_lane};
            OP_LD_H:  value_o = {{16{half_lane[15]}}, half_lane};
            OP_LD_HU: value_o = {16'd0, half_lane};
            // Word and LL pass through
            default:  value_o = rdata_i;
        endcase
    end

endmodule

`default_nettype wire

// File: mem_checker.sv
`timescale 1ns/1ps
`default_nettype none

module mem_checker (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               op_valid_i,
    input  logic               stall_i,
    input  logic               wb_valid_i,
    input  logic               wb_we_i,
    input  mem_pkg::reg_addr_t wb_rd_i,
    input  mem_pkg::word_t     wb_data_i,
    input  logic               excp_i,
    input  mem_pkg::ecode_t    excp_code_i,
    input  logic               llbit_i,
    input  logic               exp_we_i,
    input  mem_pkg::word_t     exp_data_i,
    input  mem_pkg::reg_addr_t exp_rd_i,
    input  logic               exp_excp_i,
    input  logic               exp_ll_i,
    input  int                 exp_lat_i,
    output int                 checks_o,
    output int                 errors_o
);
    import mem_pkg::*;

    logic busy;
    int   edges;
    int   n_checks = 0;
    int   n_errors = 0;

    assign checks_o = n_checks;
    assign errors_o = n_errors;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, expected, $time);
        end
    endtask

    // Edges counted from the one that accepted the operation
    always @(posedge clk) begin
        if (reset_i || wb_valid_i) begin
            busy <= 1'b0;
        end else if (op_valid_i && !stall_i) begin
            busy  <= 1'b1;
            edges <= 0;
        end else if (busy) begin
            edges <= edges + 1;
        end
    end

    always @(negedge clk) begin
        if (reset_i) begin
            compare_value("stall_o", 32'(stall_i), 32'd0);
            compare_value("wb_valid_o", 32'(wb_valid_i), 32'd0);
            compare_value("llbit_o", 32'(llbit_i), 32'd0);
        end else if (wb_valid_i) begin
            if (busy !== 1'b1) begin
                n_errors++;
                $display("wb_valid_o pulsed with no accepted operation at %0t", $time);
            end
            compare_value("wb_valid_o latency", 32'(edges), 32'(exp_lat_i));
            compare_value("wb_we_o", 32'(wb_we_i), 32'(exp_we_i));
            compare_value("excp_o", 32'(excp_i), 32'(exp_excp_i));
            compare_value("llbit_o", 32'(llbit_i), 32'(exp_ll_i));
            if (exp_we_i) begin
                compare_value("wb_data_o", wb_data_i, exp_data_i);
                compare_value("wb_rd_o", 32'(wb_rd_i), 32'(exp_rd_i));
            end
            if (exp_excp_i) begin
                compare_value("excp_code_o", 32'(excp_code_i), 32'(ECODE_ALE));
            end
        end else if (busy === 1'b1 && exp_lat_i == 2) begin
            // Memory access still in flight
            compare_value("stall_o", 32'(stall_i), 32'd1);
        end
    end

endmodule

`default_nettype wire

// File: mem_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module mem_ctrl (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               op_valid_i,
    input  mem_pkg::mem_op_e   op_i,
    input  mem_pkg::addr_t     addr_i,
    input  mem_pkg::word_t     store_data_i,
    input  mem_pkg::word_t     alu_result_i,
    input  mem_pkg::reg_addr_t rd_i,
    input  logic               llbit_clear_i,
    input  logic               misaligned_i,
    input  logic               data_ok_i,
    input  mem_pkg::word_t     load_value_i,
    output mem_pkg::mem_op_e   cur_op_o,
    output mem_pkg::addr_t     cur_addr_o,
    output mem_pkg::word_t     cur_data_o,
    output logic               mem_ce_o,
    output logic               mem_we_o,
    output logic               stall_o,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output mem_pkg::reg_addr_t wb_rd_o,
    output mem_pkg::word_t     wb_data_o,
    output logic               excp_o,
    output mem_pkg::ecode_t    excp_code_o,
    output logic               llbit_o
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        WAIT_DATA
    } state_e;

    state_e    state;
    state_e    next_state;
    word_t     alu_q;
    reg_addr_t rd_q;
    logic      is_load;
    logic      is_store;
    logic      mem_access;
    logic      wb_fire;
    logic      wb_we_d;
    logic      excp_d;
    word_t     wb_value;

    // Op class of the captured operation
    assign is_load    = cur_op_o inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W, OP_LL};
    assign is_store   = cur_op_o inside {OP_ST_B, OP_ST_H, OP_ST_W, OP_SC};
    // SC only reaches memory while the LL bit is held
    assign mem_access = (is_load || is_store) && !misaligned_i
                        && !(cur_op_o == OP_SC && !llbit_o);

    assign mem_ce_o = (state == ACCESS) && mem_access;
    assign mem_we_o = mem_ce_o && is_store;
    assign stall_o  = (state != IDLE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (op_valid_i) next_state = ACCESS;
            ACCESS:    next_state = mem_access ? WAIT_DATA : IDLE;
            WAIT_DATA: if (data_ok_i) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // Operation is captured only while idle
    always_ff @(posedge clk) begin
        if (state == IDLE && op_valid_i) begin
            cur_op_o   <= op_i;
            cur_addr_o <= addr_i;
            cur_data_o <= store_data_i;
            alu_q      <= alu_result_i;
            rd_q       <= rd_i;
        end
    end

    always_comb begin
        wb_fire  = 1'b0;
        wb_we_d  = 1'b0;
        excp_d   = 1'b0;
        wb_value = alu_q;
        if (state == ACCESS && !mem_access) begin
            // NOP, misaligned or failed SC
            wb_fire = 1'b1;
            if (misaligned_i) begin
                excp_d = 1'b1;
            end else begin
                wb_we_d  = 1'b1;
                wb_value = (cur_op_o == OP_SC) ? 32'd0 : alu_q;
            end
        end else if (state == WAIT_DATA && data_ok_i) begin
            wb_fire  = 1'b1;
            wb_we_d  = is_load || (cur_op_o == OP_SC);
            wb_value = (cur_op_o == OP_SC) ? 32'd1 : load_value_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o <= 1'b0;
            wb_we_o    <= 1'b0;
            excp_o     <= 1'b0;
        end else begin
            wb_valid_o <= wb_fire;
            wb_we_o    <= wb_fire && wb_we_d;
            excp_o     <= wb_fire && excp_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_fire) begin
            wb_rd_o     <= rd_q;
            wb_data_o   <= wb_value;
            excp_code_o <= excp_d ? ECODE_ALE : ecode_t'(0);
        end
    end

    // External clear wins over LL and SC
    always_ff @(posedge clk) begin
        if (reset_i || llbit_clear_i) begin
            llbit_o <= 1'b0;
        end else if (state == WAIT_DATA && data_ok_i) begin
            if (cur_op_o == OP_LL) begin
                llbit_o <= 1'b1;
            end else if (cur_op_o == OP_SC) begin
                llbit_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    // Data memory geometry
    localparam int MEM_DEPTH_WORDS = 256;
    localparam int MEM_INDEX_W     = 8;

    // Alignment exception code
    localparam logic [5:0] ECODE_ALE = 6'h09;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_sel_t;
    typedef logic [5:0]  ecode_t;

    // OP_NOP passes the ALU result through
    typedef enum logic [3:0] {
        OP_NOP,
        OP_LD_B,
        OP_LD_BU,
        OP_LD_H,
        OP_LD_HU,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W,
        OP_LL,
        OP_SC
    } mem_op_e;

endpackage

`default_nettype wire

// File: mem_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage_top (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               op_valid_i,
    input  mem_pkg::mem_op_e   op_i,
    input  mem_pkg::addr_t     addr_i,
    input  mem_pkg::word_t     store_data_i,
    input  mem_pkg::word_t     alu_result_i,
    input  mem_pkg::reg_addr_t rd_i,
    input  logic               llbit_clear_i,
    output logic               stall_o,
    output logic               wb_valid_o,
    output logic               wb_we_o,
    output mem_pkg::reg_addr_t wb_rd_o,
    output mem_pkg::word_t     wb_data_o,
    output logic               excp_o,
    output mem_pkg::ecode_t    excp_code_o,
    output logic               llbit_o
);
    import mem_pkg::*;

    mem_op_e   cur_op;
    addr_t     cur_addr;
    word_t     cur_data;
    logic      mem_ce;
    logic      mem_we;
    byte_sel_t mem_sel;
    word_t     mem_wdata;
    word_t     mem_rdata;
    logic      data_ok;
    logic      misaligned;
    word_t     load_value;

    mem_ctrl u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .op_valid_i    (op_valid_i),
        .op_i          (op_i),
        .addr_i        (addr_i),
        .store_data_i  (store_data_i),
        .alu_result_i  (alu_result_i),
        .rd_i          (rd_i),
        .llbit_clear_i (llbit_clear_i),
        .misaligned_i  (misaligned),
        .data_ok_i     (data_ok),
        .load_value_i  (load_value),
        .cur_op_o      (cur_op),
        .cur_addr_o    (cur_addr),
        .cur_data_o    (cur_data),
        .mem_ce_o      (mem_ce),
        .mem_we_o      (mem_we),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .excp_o        (excp_o),
        .excp_code_o   (excp_code_o),
        .llbit_o       (llbit_o)
    );

    store_align u_store_align (
        .op_i         (cur_op),
        .addr_low_i   (cur_addr[1:0]),
        .store_data_i (cur_data),
        .sel_o        (mem_sel),
        .wdata_o      (mem_wdata),
        .misaligned_o (misaligned)
    );

    load_extract u_load_extract (
        .op_i       (cur_op),
        .addr_low_i (cur_addr[1:0]),
        .rdata_i    (mem_rdata),
        .value_o    (load_value)
    );

    data_sram u_sram (
        .clk       (clk),
        .reset_i   (reset_i),
        .ce_i      (mem_ce),
        .we_i      (mem_we),
        .addr_i    (cur_addr),
        .sel_i     (mem_sel),
        .wdata_i   (mem_wdata),
        .rdata_o   (mem_rdata),
        .data_ok_o (data_ok)
    );

endmodule

`default_nettype wire

// File: store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
    input  mem_pkg::mem_op_e  op_i,
    input  logic [1:0]        addr_low_i,
    input  mem_pkg::word_t    store_data_i,
    output mem_pkg::byte_sel_t sel_o,
    output mem_pkg::word_t    wdata_o,
    output logic              misaligned_o
);
    import mem_pkg::*;

    always_comb begin
        sel_o        = '0;
        wdata_o      = store_data_i;
        misaligned_o = 1'b0;
        case (op_i)
            OP_LD_B, OP_LD_BU, OP_ST_B: begin
                // One lane per offset
                case (addr_low_i)
                    2'b00:   sel_o = 4'b0001;
                    2'b01:   sel_o = 4'b0010;
                    2'b10:   sel_o = 4'b0100;
                    default: sel_o = 4'b1000;
                endcase
                wdata_o = {4{store_data_i[7:0]}};
            end
            OP_LD_H, OP_LD_HU, OP_ST_H: begin
                sel_o        = addr_low_i[1] ? 4'b1100 : 4'b0011;
                wdata_o      = {2{store_data_i[15:0]}};
                misaligned_o = addr_low_i[0];
            end
            OP_LD_W, OP_ST_W, OP_LL, OP_SC: begin
                sel_o        = 4'b1111;
                misaligned_o = (addr_low_i != 2'b00);
            end
            default: begin
                sel_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;
    import mem_pkg::*;

    localparam int WAIT_LIMIT = 20;

    logic      clk;
    logic      reset_i;
    logic      op_valid_i;
    mem_op_e   op_i;
    addr_t     addr_i;
    word_t     store_data_i;
    word_t     alu_result_i;
    reg_addr_t rd_i;
    logic      llbit_clear_i;
    logic      stall_o;
    logic      wb_valid_o;
    logic      wb_we_o;
    reg_addr_t wb_rd_o;
    word_t     wb_data_o;
    logic      excp_o;
    ecode_t    excp_code_o;
    logic      llbit_o;

    logic      exp_we;
    word_t     exp_data;
    reg_addr_t exp_rd;
    logic      exp_excp;
    logic      exp_ll;
    int        exp_lat;
    int        checks;
    int        errors;
    int        timeouts;
    bit        ok;
    word_t     rnd [3];

    // Flags column holds {wb_we, excp, llbit after, clear LL bit first}
    mem_op_e   t_op [$];
    addr_t     t_addr [$];
    word_t     t_wdata [$];
    word_t     t_alu [$];
    reg_addr_t t_rd [$];
    word_t     t_data [$];
    logic [3:0] t_flags [$];

    mem_stage_top u_dut (
        .clk           (clk),
        .reset_i       (reset_i),
        .op_valid_i    (op_valid_i),
        .op_i          (op_i),
        .addr_i        (addr_i),
        .store_data_i  (store_data_i),
        .alu_result_i  (alu_result_i),
        .rd_i          (rd_i),
        .llbit_clear_i (llbit_clear_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_we_o       (wb_we_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .excp_o        (excp_o),
        .excp_code_o   (excp_code_o),
        .llbit_o       (llbit_o)
    );

    mem_checker u_check (
        .clk         (clk),
        .reset_i     (reset_i),
        .op_valid_i  (op_valid_i),
        .stall_i     (stall_o),
        .wb_valid_i  (wb_valid_o),
        .wb_we_i     (wb_we_o),
        .wb_rd_i     (wb_rd_o),
        .wb_data_i   (wb_data_o),
        .excp_i      (excp_o),
        .excp_code_i (excp_code_o),
        .llbit_i     (llbit_o),
        .exp_we_i    (exp_we),
        .exp_data_i  (exp_data),
        .exp_rd_i    (exp_rd),
        .exp_excp_i  (exp_excp),
        .exp_ll_i    (exp_ll),
        .exp_lat_i   (exp_lat),
        .checks_o    (checks),
        .errors_o    (errors)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic add_entry(input mem_op_e op, input addr_t addr, input word_t wdata,
                             input word_t alu, input reg_addr_t rd, input word_t data,
                             input logic [3:0] flags);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_alu.push_back(alu);
        t_rd.push_back(rd);
        t_data.push_back(data);
        t_flags.push_back(flags);
    endtask

    task automatic build_table();
        // op, addr, store data, alu result, rd, expected data, flags
        add_entry(OP_ST_W,  32'h010, rnd[0],        32'h0, 5'd1,  32'h0,         4'b0000);
        add_entry(OP_LD_W,  32'h010, 32'h0,         32'h0, 5'd2,  rnd[0],        4'b1000);
        // Known word for the lane tests
        add_entry(OP_ST_W,  32'h020, 32'h8a7f_05f6, 32'h0, 5'd3,  32'h0,         4'b0000);
        add_entry(OP_LD_B,  32'h020, 32'h0,         32'h0, 5'd4,  32'hffff_fff6, 4'b1000);
        add_entry(OP_LD_B,  32'h021, 32'h0,         32'h0, 5'd5,  32'h0000_0005, 4'b1000);
        add_entry(OP_LD_B,  32'h022, 32'h0,         32'h0, 5'd6,  32'h0000_007f, 4'b1000);
        add_entry(OP_LD_B,  32'h023, 32'h0,         32'h0, 5'd7,  32'hffff_ff8a, 4'b1000);
        add_entry(OP_LD_BU, 32'h020, 32'h0,         32'h0, 5'd8,  32'h0000_00f6, 4'b1000);
        add_entry(OP_LD_BU, 32'h021, 32'h0,         32'h0, 5'd9,  32'h0000_0005, 4'b1000);
        add_entry(OP_LD_BU, 32'h022, 32'h0,         32'h0, 5'd10, 32'h0000_007f, 4'b1000);
        add_entry(OP_LD_BU, 32'h023, 32'h0,         32'h0, 5'd11, 32'h0000_008a, 4'b1000);
        add_entry(OP_LD_H,  32'h020, 32'h0,         32'h0, 5'd12, 32'h0000_05f6, 4'b1000);
        add_entry(OP_LD_H,  32'h022, 32'h0,         32'h0, 5'd13, 32'hffff_8a7f, 4'b1000);
        add_entry(OP_LD_HU, 32'h020, 32'h0,         32'h0, 5'd14, 32'h0000_05f6, 4'b1000);
        add_entry(OP_LD_HU, 32'h022, 32'h0,         32'h0, 5'd15, 32'h0000_8a7f, 4'b1000);
        // Partial stores merge into the word and ignore the upper store data bits
        add_entry(OP_ST_W,  32'h030, rnd[1],        32'h0, 5'd16, 32'h0,         4'b0000);
        add_entry(OP_ST_B,  32'h031, 32'h1234_56c3, 32'h0, 5'd17, 32'h0,         4'b0000);
        add_entry(OP_ST_H,  32'h032, 32'hdead_5ab4, 32'h0, 5'd18, 32'h0,         4'b0000);
        add_entry(OP_LD_W,  32'h030, 32'h0,         32'h0, 5'd19,
                  {16'h5ab4, 8'hc3, rnd[1][7:0]}, 4'b1000);
        // LL and SC sequence
        add_entry(OP_ST_W,  32'h040, rnd[2],        32'h0, 5'd20, 32'h0,         4'b0000);
        add_entry(OP_LL,    32'h040, 32'h0,         32'h0, 5'd21, rnd[2],        4'b1010);
        add_entry(OP_SC,    32'h040, 32'h600d_cafe, 32'h0, 5'd22, 32'h1,         4'b1000);
        add_entry(OP_LD_W,  32'h040, 32'h0,         32'h0, 5'd23, 32'h600d_cafe, 4'b1000);
        add_entry(OP_SC,    32'h040, 32'hbad0_0001, 32'h0, 5'd24, 32'h0,         4'b1000);
        add_entry(OP_LD_W,  32'h040, 32'h0,         32'h0, 5'd25, 32'h600d_cafe, 4'b1000);
        add_entry(OP_LL,    32'h040, 32'h0,         32'h0, 5'd26, 32'h600d_cafe, 4'b1010);
        add_entry(OP_SC,    32'h040, 32'h0bad_0002, 32'h0, 5'd27, 32'h0,         4'b1001);
        add_entry(OP_LD_W,  32'h040, 32'h0,         32'h0, 5'd28, 32'h600d_cafe, 4'b1000);
        // Misaligned accesses must leave memory intact
        add_entry(OP_ST_H,  32'h021, 32'hffff_ffff, 32'h0, 5'd29, 32'h0,         4'b0100);
        add_entry(OP_ST_W,  32'h022, 32'hffff_ffff, 32'h0, 5'd30, 32'h0,         4'b0100);
        add_entry(OP_LD_H,  32'h023, 32'h0,         32'h0, 5'd1,  32'h0,         4'b0100);
        add_entry(OP_LD_W,  32'h021, 32'h0,         32'h0, 5'd2,  32'h0,         4'b0100);
        add_entry(OP_LL,    32'h022, 32'h0,         32'h0, 5'd3,  32'h0,         4'b0100);
        add_entry(OP_LD_W,  32'h020, 32'h0,         32'h0, 5'd4,  32'h8a7f_05f6, 4'b1000);
        add_entry(OP_NOP,   32'h0,   32'h0, 32'h1357_9bdf, 5'd7,  32'h1357_9bdf, 4'b1000);
        add_entry(OP_NOP,   32'h0,   32'h0, 32'hfedc_ba98, 5'd31, 32'hfedc_ba98, 4'b1000);
    endtask

    // Cycles from acceptance to wb_valid_o
    function automatic int expected_latency(input mem_op_e op, input logic excp,
                                            input word_t data);
        if (op == OP_NOP || excp || (op == OP_SC && data == 32'd0)) begin
            return 1;
        end
        return 2;
    endfunction

    task automatic wait_idle(output bit found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < WAIT_LIMIT) begin
            @(negedge clk);
            found = !stall_o;
            n++;
        end
    endtask

    task automatic wait_writeback(output bit found);
        int n;
        found = 1'b0;
        n = 0;
        while (!found && n < WAIT_LIMIT) begin
            @(negedge clk);
            found = wb_valid_o;
            n++;
        end
    endtask

    initial begin
        reset_i       = 1'b1;
        op_valid_i    = 1'b0;
        op_i          = OP_NOP;
        addr_i        = '0;
        store_data_i  = '0;
        alu_result_i  = '0;
        rd_i          = '0;
        llbit_clear_i = 1'b0;
        exp_we        = 1'b0;
        exp_data      = '0;
        exp_rd        = '0;
        exp_excp      = 1'b0;
        exp_ll        = 1'b0;
        exp_lat       = 0;
        timeouts      = 0;
        void'($urandom(32'h2a83_1da8));
        for (int k = 0; k < 3; k++) begin
            rnd[k] = $urandom();
        end
        build_table();

        repeat (5) @(posedge clk);
        reset_i <= 1'b0;

        for (int i = 0; i < t_op.size() && timeouts == 0; i++) begin
            wait_idle(ok);
            if (!ok) begin
                $display("Timeout: stall_o stayed high before entry %0d", i);
                timeouts++;
            end else begin
                @(posedge clk);
                if (t_flags[i][0]) begin
                    llbit_clear_i <= 1'b1;
                    @(posedge clk);
                    llbit_clear_i <= 1'b0;
                end
                exp_we       <= t_flags[i][3];
                exp_excp     <= t_flags[i][2];
                exp_ll       <= t_flags[i][1];
                exp_data     <= t_data[i];
                exp_rd       <= t_rd[i];
                exp_lat      <= expected_latency(t_op[i], t_flags[i][2], t_data[i]);
                op_valid_i   <= 1'b1;
                op_i         <= t_op[i];
                addr_i       <= t_addr[i];
                store_data_i <= t_wdata[i];
                alu_result_i <= t_alu[i];
                rd_i         <= t_rd[i];
                @(posedge clk);
                op_valid_i <= 1'b0;
                wait_writeback(ok);
                if (!ok) begin
                    $display("Timeout: no wb_valid_o for entry %0d", i);
                    timeouts++;
                end
            end
        end

        // Let the checker finish its last comparison
        @(posedge clk);
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
